// File: verilog/matmul_macros.svh
`ifndef MATMUL_MACROS_SVH
`define MATMUL_MACROS_SVH

// width of one unsigned operand element
`define MATMUL_ELEM_W 5

// rows and columns of every matrix
`define MATMUL_DIM 3
`define MATMUL_CELLS 9

// 3 * 31 * 31 = 2883 needs 12 bits
`define MATMUL_ACC_W 12

`endif

// File: verilog/matmul_data_pkg.sv
`include "matmul_macros.svh"

package matmul_data_pkg;

    // one operand element of A or B
    typedef logic [`MATMUL_ELEM_W-1:0] elem_t;

    // one result element of C, wide enough for a full dot product
    typedef logic [`MATMUL_ACC_W-1:0] acc_t;

    // cell k holds row k / 3 and column k % 3
    typedef elem_t elem_mat_t [`MATMUL_CELLS];
    typedef acc_t acc_mat_t [`MATMUL_CELLS];

endpackage

// File: verilog/matmul_ctrl_pkg.sv
`include "matmul_macros.svh"

package matmul_ctrl_pkg;

    // index of one result cell, 0 to 8
    typedef logic [$clog2(`MATMUL_CELLS)-1:0] cell_idx_t;

    typedef enum logic [1:0] {
        seq_idle,
        seq_issue,
        seq_drain
    } seq_state_t;

endpackage

// File: verilog/matrix_bank.sv
`timescale 1ns/100ps

`include "matmul_macros.svh"

module matrix_bank #(
    parameter type cell_t = logic
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [`MATMUL_CELLS-1:0] wr_mask,
    input  cell_t                    d [`MATMUL_CELLS],
    output cell_t                    q [`MATMUL_CELLS]
);

    // every cell loads on its own mask bit, the others hold
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < `MATMUL_CELLS; k++) begin
                q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < `MATMUL_CELLS; k++) begin
                if (wr_mask[k]) begin
                    q[k] <= d[k];
                end
            end
        end
    end

endmodule

// File: verilog/dot_product_pipe.sv
`timescale 1ns/100ps

`include "matmul_macros.svh"

module dot_product_pipe (
    input  logic                       clk,
    input  logic                       arst_n,
    input  matmul_data_pkg::elem_mat_t a_mat,
    input  matmul_data_pkg::elem_mat_t b_mat,
    input  logic                       issue_valid,
    input  matmul_ctrl_pkg::cell_idx_t issue_idx,
    output logic                       res_valid,
    output matmul_ctrl_pkg::cell_idx_t res_idx,
    output matmul_data_pkg::acc_t      res_data
);

    matmul_ctrl_pkg::cell_idx_t row;
    matmul_ctrl_pkg::cell_idx_t col;

    logic [2*`MATMUL_ELEM_W-1:0] prod_q [`MATMUL_DIM];
    logic                        s1_valid;
    matmul_ctrl_pkg::cell_idx_t  s1_idx;

    matmul_data_pkg::acc_t sum;

    // result cell k is row k / 3 of A times column k % 3 of B
    assign row = matmul_ctrl_pkg::cell_idx_t'(issue_idx / `MATMUL_DIM);
    assign col = matmul_ctrl_pkg::cell_idx_t'(issue_idx % `MATMUL_DIM);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
        end
    end

    // stage one holds the three partial products of the issued cell
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            s1_idx <= issue_idx;
            for (int j = 0; j < `MATMUL_DIM; j++) begin
                prod_q[j] <= a_mat[row*`MATMUL_DIM + j] * b_mat[j*`MATMUL_DIM + col];
            end
        end
    end

    // products are zero extended before the add so the sum cannot wrap
    always_comb begin
        sum = '0;
        for (int j = 0; j < `MATMUL_DIM; j++) begin
            sum = sum + matmul_data_pkg::acc_t'(prod_q[j]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= s1_valid;
        end
    end

    // stage two holds the finished element and where it goes
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            res_idx  <= s1_idx;
            res_data <= sum;
        end
    end

endmodule

// File: verilog/matmul_sequencer.sv
`timescale 1ns/100ps

`include "matmul_macros.svh"

module matmul_sequencer (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       start,
    input  logic                       res_valid,
    input  matmul_ctrl_pkg::cell_idx_t res_idx,
    output logic                       issue_valid,
    output matmul_ctrl_pkg::cell_idx_t issue_idx,
    output logic                       busy,
    output logic                       done
);

    matmul_ctrl_pkg::seq_state_t state;
    matmul_ctrl_pkg::cell_idx_t  cnt;
    logic                        last_seen;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= matmul_ctrl_pkg::seq_idle;
            cnt         <= '0;
            issue_valid <= 1'b0;
            issue_idx   <= '0;
            last_seen   <= 1'b0;
            done        <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                matmul_ctrl_pkg::seq_idle: begin
                    // start only counts here, so a pulse while busy is dropped
                    if (start) begin
                        state <= matmul_ctrl_pkg::seq_issue;
                        cnt   <= '0;
                    end
                end
                matmul_ctrl_pkg::seq_issue: begin
                    issue_valid <= 1'b1;
                    issue_idx   <= cnt;
                    cnt         <= cnt + 1'b1;
                    if (cnt == matmul_ctrl_pkg::cell_idx_t'(`MATMUL_CELLS - 1)) begin
                        state <= matmul_ctrl_pkg::seq_drain;
                    end
                end
                matmul_ctrl_pkg::seq_drain: begin
                    issue_valid <= 1'b0;
                    // the last cell lands in C on the edge that sets last_seen
                    if (last_seen) begin
                        last_seen <= 1'b0;
                        done      <= 1'b1;
                        state     <= matmul_ctrl_pkg::seq_idle;
                    end else if (res_valid &&
                                 res_idx == matmul_ctrl_pkg::cell_idx_t'(`MATMUL_CELLS - 1)) begin
                        last_seen <= 1'b1;
                    end
                end
                default: begin
                    state <= matmul_ctrl_pkg::seq_idle;
                end
            endcase
        end
    end

    assign busy = (state != matmul_ctrl_pkg::seq_idle);

endmodule

// File: verilog/matmul_top.sv
`timescale 1ns/100ps

`include "matmul_macros.svh"

module matmul_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [`MATMUL_CELLS-1:0]   a_wr_mask,
    input  logic [`MATMUL_CELLS-1:0]   b_wr_mask,
    input  matmul_data_pkg::elem_mat_t a_in,
    input  matmul_data_pkg::elem_mat_t b_in,
    input  logic                       start,
    output logic                       busy,
    output logic                       done,
    output matmul_data_pkg::acc_mat_t  c_out
);

    matmul_data_pkg::elem_mat_t a_q;
    matmul_data_pkg::elem_mat_t b_q;
    matmul_data_pkg::acc_mat_t  c_d;
    logic [`MATMUL_CELLS-1:0]   c_wr_mask;

    logic                       issue_valid;
    matmul_ctrl_pkg::cell_idx_t issue_idx;
    logic                       res_valid;
    matmul_ctrl_pkg::cell_idx_t res_idx;
    matmul_data_pkg::acc_t      res_data;

    matrix_bank #(
        .cell_t (matmul_data_pkg::elem_t)
    ) a_bank (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_mask (a_wr_mask),
        .d       (a_in),
        .q       (a_q)
    );

    matrix_bank #(
        .cell_t (matmul_data_pkg::elem_t)
    ) b_bank (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_mask (b_wr_mask),
        .d       (b_in),
        .q       (b_q)
    );

    matmul_sequencer u_sequencer (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .res_valid   (res_valid),
        .res_idx     (res_idx),
        .issue_valid (issue_valid),
        .issue_idx   (issue_idx),
        .busy        (busy),
        .done        (done)
    );

    dot_product_pipe u_pipe (
        .clk         (clk),
        .arst_n      (arst_n),
        .a_mat       (a_q),
        .b_mat       (b_q),
        .issue_valid (issue_valid),
        .issue_idx   (issue_idx),
        .res_valid   (res_valid),
        .res_idx     (res_idx),
        .res_data    (res_data)
    );

    // one result per cycle, so only the addressed cell of C opens
    always_comb begin
        c_wr_mask = '0;
        if (res_valid) begin
            c_wr_mask[res_idx] = 1'b1;
        end
    end

    always_comb begin
        for (int k = 0; k < `MATMUL_CELLS; k++) begin
            c_d[k] = res_data;
        end
    end

    matrix_bank #(
        .cell_t (matmul_data_pkg::acc_t)
    ) c_bank (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_mask (c_wr_mask),
        .d       (c_d),
        .q       (c_out)
    );

endmodule

// File: bench/tb_matmul.sv
`timescale 1ns/100ps

`include "matmul_macros.svh"

module tb_matmul;

    logic                       clk;
    logic                       arst_n;
    logic [`MATMUL_CELLS-1:0]   a_wr_mask;
    logic [`MATMUL_CELLS-1:0]   b_wr_mask;
    matmul_data_pkg::elem_mat_t a_in;
    matmul_data_pkg::elem_mat_t b_in;
    logic                       start;
    logic                       busy;
    logic                       done;
    matmul_data_pkg::acc_mat_t  c_out;

    integer seed;
    int     model_a [`MATMUL_CELLS];
    int     model_b [`MATMUL_CELLS];
    int     mismatch_count;
    int     timeout_count;
    int     other_count;

    matmul_top dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .a_wr_mask (a_wr_mask),
        .b_wr_mask (b_wr_mask),
        .a_in      (a_in),
        .b_in      (b_in),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .c_out     (c_out)
    );

    always #2 clk = ~clk;

    // the actual value stays four-state so an unknown output never matches
    task automatic check_value(input string name, input int expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
            mismatch_count++;
        end
    endtask

    // row k / 3 of A times column k % 3 of B, in plain integers
    function automatic int expected_cell(input int k);
        int row;
        int col;
        int sum;
        row = k / `MATMUL_DIM;
        col = k % `MATMUL_DIM;
        sum = 0;
        for (int j = 0; j < `MATMUL_DIM; j++) begin
            sum += model_a[row*`MATMUL_DIM + j] * model_b[j*`MATMUL_DIM + col];
        end
        return sum;
    endfunction

    task automatic compare_product(input string name);
        for (int k = 0; k < `MATMUL_CELLS; k++) begin
            check_value($sformatf("%s c[%0d]", name, k), expected_cell(k), c_out[k]);
        end
    endtask

    // called on a falling edge, returns on the falling edge after the write
    task automatic load_operands(input logic [`MATMUL_CELLS-1:0] am,
                                 input logic [`MATMUL_CELLS-1:0] bm,
                                 input bit all_max);
        int value;
        int max_value;
        max_value = (1 << `MATMUL_ELEM_W) - 1;
        for (int k = 0; k < `MATMUL_CELLS; k++) begin
            value = all_max ? max_value : ($random(seed) & max_value);
            a_in[k] = value;
            if (am[k]) begin
                model_a[k] = value;
            end
            value = all_max ? max_value : ($random(seed) & max_value);
            b_in[k] = value;
            if (bm[k]) begin
                model_b[k] = value;
            end
        end
        a_wr_mask = am;
        b_wr_mask = bm;
        @(negedge clk);
        a_wr_mask = '0;
        b_wr_mask = '0;
    endtask

    // start is sampled on the next rising edge, done is expected 13 edges later
    task automatic run_and_check(input string name, input bit extra_starts);
        int cycles;
        bit seen;
        start = 1'b1;
        @(posedge clk);
        @(negedge clk);
        start = 1'b0;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < 50) begin
            @(negedge clk);
            cycles++;
            if (done) begin
                seen = 1'b1;
            end else begin
                check_value({name, " busy"}, 1, busy);
                // these pulses land while the sequencer is busy and must be dropped
                start = extra_starts && (cycles == 3 || cycles == 8);
            end
        end
        start = 1'b0;
        assert (seen) else begin
            $display("%s: done never arrived within 50 cycles", name);
            timeout_count++;
        end
        if (seen) begin
            check_value({name, " latency"}, 13, cycles);
            check_value({name, " busy at done"}, 0, busy);
            compare_product(name);
        end
    endtask

    task automatic watch_for_stray_done(input string name, input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(negedge clk);
            assert (!done && !busy) else begin
                $display("%s: a second run started from a start given while busy", name);
                other_count++;
            end
        end
    endtask

    initial begin
        seed = 50034;
        mismatch_count = 0;
        timeout_count = 0;
        other_count = 0;
        clk = 1'b0;
        arst_n = 1'b0;
        start = 1'b0;
        a_wr_mask = '0;
        b_wr_mask = '0;
        for (int k = 0; k < `MATMUL_CELLS; k++) begin
            a_in[k] = '0;
            b_in[k] = '0;
            model_a[k] = 0;
            model_b[k] = 0;
        end

        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        check_value("reset busy", 0, busy);
        check_value("reset done", 0, done);
        for (int k = 0; k < `MATMUL_CELLS; k++) begin
            check_value($sformatf("reset c[%0d]", k), 0, c_out[k]);
        end

        for (int n = 0; n < 20; n++) begin
            load_operands('1, '1, 1'b0);
            run_and_check($sformatf("full load %0d", n), 1'b0);
        end

        // masked writes, the model keeps the cells that are not written
        for (int n = 0; n < 12; n++) begin
            load_operands($random(seed), $random(seed), 1'b0);
            run_and_check($sformatf("partial load %0d", n), 1'b0);
        end

        load_operands('1, '1, 1'b0);
        run_and_check("start while busy", 1'b1);
        watch_for_stray_done("start while busy", 20);

        load_operands('1, '1, 1'b1);
        run_and_check("all max", 1'b0);
        for (int k = 0; k < `MATMUL_CELLS; k++) begin
            check_value($sformatf("all max width c[%0d]", k), 3 * 31 * 31, c_out[k]);
        end
        // restart on the falling edge right after done
        run_and_check("back to back start", 1'b0);

        $display("errors: %0d mismatches, %0d timeouts, %0d other failures",
                 mismatch_count, timeout_count, other_count);
        if (mismatch_count + timeout_count + other_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+verilog
verilog/matmul_data_pkg.sv
verilog/matmul_ctrl_pkg.sv
verilog/matrix_bank.sv
verilog/dot_product_pipe.sv
verilog/matmul_sequencer.sv
verilog/matmul_top.sv
bench/tb_matmul.sv

// File: Bender.yml
package:
  name: matmul

export_include_dirs:
  - verilog

sources:
  # design, packages first
  - include_dirs:
      - verilog
    files:
      - verilog/matmul_data_pkg.sv
      - verilog/matmul_ctrl_pkg.sv
      - verilog/matrix_bank.sv
      - verilog/dot_product_pipe.sv
      - verilog/matmul_sequencer.sv
      - verilog/matmul_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - bench/tb_matmul.sv
